// File: rv_core.f
verilog/rv_isa_pkg.sv
verilog/rv_ctrl_pkg.sv
verilog/rv_exec_if.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_core.sv
tests/rv_core_properties.sv
tests/rv_core_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module rv_core_tb -f rv_core.f
	./obj_dir/Vrv_core_tb > $(LOG) 2>&1 || echo "Regression failed" >> $(LOG)
	cat $(LOG)
	! grep -q "Regression failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/rv_core_tb.sv
// Testbench running directed and random programs on the RV32I core against a reference model
`default_nettype none

module rv_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam rv_isa_pkg::word_t start_pc = 32'h100;
    localparam int period        = 40;
    localparam int reset_len     = 16;
    localparam int n_random      = 40;  // Instructions per random test
    localparam int max_gap       = 3;
    localparam int settle_cycles = 12;
    localparam int n_tests       = 6;
    localparam int n_instr       = 31 + 62 + 3 * n_random + 50;
    localparam int watchdog_ns   =
        (reset_len + n_instr * (1 + max_gap) + n_tests * settle_cycles) * period * 2;

    logic                  clk;
    logic                  reset;
    logic                  instr_valid;
    rv_isa_pkg::word_t     instr;
    logic                  wb_valid;
    rv_isa_pkg::reg_addr_t wb_rd;
    rv_isa_pkg::word_t     wb_data;

    rv_isa_pkg::word_t     model_regs [32];
    rv_isa_pkg::word_t     model_pc;
    logic                  pend_live;   // Result not yet visible to the next strobe
    rv_isa_pkg::reg_addr_t pend_rd;
    rv_isa_pkg::word_t     pend_data;
    int                    pend_edge;
    int                    edge_count;
    logic [36:0]           expect_q [$]; // Expected rd above data
    int                    errors;
    int                    test_errors;
    int                    tests_run;
    int                    tests_failed;
    int                    checks;

    rv_core #(
        .reset_pc (start_pc)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    function automatic rv_isa_pkg::word_t encode_reg_op(input logic alt, input logic [4:0] rd,
            input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_isa_pkg::op_reg};
    endfunction

    function automatic rv_isa_pkg::word_t encode_imm_op(input logic [11:0] imm,
            input logic [4:0] rd, input logic [2:0] f3, input logic [4:0] rs1);
        return {imm, rs1, f3, rd, rv_isa_pkg::op_imm};
    endfunction

    function automatic rv_isa_pkg::word_t encode_upper(input logic [6:0] op, input logic [4:0] rd,
            input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    // RV32I semantics of the kept instructions
    function automatic rv_isa_pkg::word_t expected_result(input rv_isa_pkg::word_t word,
            input rv_isa_pkg::word_t a, input rv_isa_pkg::word_t b_reg,
            input rv_isa_pkg::word_t pc);
        rv_isa_pkg::word_t b;
        logic [4:0]        sh;
        logic              alt;
        b   = (word[6:0] == rv_isa_pkg::op_reg) ? b_reg : {{20{word[31]}}, word[31:20]};
        sh  = b[4:0];
        alt = word[30];
        if (word[6:0] == rv_isa_pkg::op_lui) begin
            return {word[31:12], 12'b0};
        end
        if (word[6:0] == rv_isa_pkg::op_auipc) begin
            return pc + {word[31:12], 12'b0};
        end
        case (word[14:12])
            rv_isa_pkg::f3_add: begin
                if (alt && word[6:0] == rv_isa_pkg::op_reg) begin
                    return a - b;
                end
                return a + b;
            end
            rv_isa_pkg::f3_sll:  return a << sh;
            rv_isa_pkg::f3_slt:  return {31'b0, $signed(a) < $signed(b)};
            rv_isa_pkg::f3_sltu: return {31'b0, a < b};
            rv_isa_pkg::f3_xor:  return a ^ b;
            rv_isa_pkg::f3_srl: begin
                if (alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            rv_isa_pkg::f3_or:   return a | b;
            default:             return a & b;
        endcase
    endfunction

    task automatic commit_pending();
        if (pend_live && pend_rd != 5'd0) begin
            model_regs[pend_rd] = pend_data; // x0 stays zero
        end
        pend_live = 1'b0;
    endtask

    // One strobe followed by gap idle cycles
    task automatic issue(input rv_isa_pkg::word_t word, input int gap);
        rv_isa_pkg::word_t result;
        logic              kept;
        @(negedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        if (pend_live && edge_count - pend_edge >= 2) begin
            commit_pending();
        end
        kept = word[6:0] inside {rv_isa_pkg::op_reg, rv_isa_pkg::op_imm,
                                 rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc};
        result = expected_result(word, model_regs[word[19:15]], model_regs[word[24:20]],
                                 model_pc);
        commit_pending(); // Previous result is visible from the next strobe on
        if (kept) begin
            expect_q.push_back({word[11:7], result});
            pend_live = 1'b1;
            pend_rd   = word[11:7];
            pend_data = result;
            pend_edge = edge_count;
        end
        model_pc = model_pc + 32'd4;
        repeat (gap) begin
            @(negedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        instr_valid <= 1'b0;
        while (expect_q.size() != 0 && waited < settle_cycles) begin
            @(negedge clk);
            waited++;
        end
        repeat (2) @(negedge clk); // Room for a stray write-back
        @(posedge clk);
        if (expect_q.size() != 0) begin
            $display("[%0t] %s: %0d expected write-backs never arrived", $time, name,
                     expect_q.size());
            test_errors++;
            expect_q.delete();
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    // Write-backs compared in order at mid-cycle where outputs are stable
    always @(negedge clk) begin
        logic [36:0] expected;
        if (!reset && wb_valid) begin
            checks++;
            if (expect_q.size() == 0) begin
                $display("[%0t] unexpected write-back to x%0d with data %h", $time, wb_rd,
                         wb_data);
                test_errors++;
            end else begin
                expected = expect_q.pop_front();
                if (wb_rd !== expected[36:32]) begin
                    $display("mismatch at %0t: wb_rd is %0d, expected %0d", $time, wb_rd,
                             expected[36:32]);
                    test_errors++;
                end
                if (wb_data !== expected[31:0]) begin
                    $display("mismatch at %0t: wb_data is %h, expected %h", $time, wb_data,
                             expected[31:0]);
                    test_errors++;
                end
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog timeout after %0d ns, the run did not complete", watchdog_ns);
        $display("Regression failed");
        $finish;
    end

    initial begin
        rv_isa_pkg::word_t value;
        rv_isa_pkg::word_t word;
        logic [2:0]        f3;
        logic              alt;
        logic [11:0]       imm;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        int                sel;
        void'($urandom(32'hc81a));
        instr_valid = 1'b0;
        instr       = '0;
        reset       = 1'b1;
        model_pc    = start_pc;
        pend_live   = 1'b0;
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (reset_len) @(negedge clk);
        reset <= 1'b0;

        // Idle pipeline and then every register reads zero
        repeat (8) begin
            @(negedge clk);
            if (wb_valid !== 1'b0) begin
                $display("mismatch at %0t: wb_valid is %b, expected 0", $time, wb_valid);
                test_errors++;
            end
        end
        for (int r = 1; r < 32; r++) begin
            issue(encode_imm_op(12'h0, 5'(r), rv_isa_pkg::f3_add, 5'(r)), 1);
        end
        finish_test("reset_state");

        for (int r = 1; r < 32; r++) begin
            value = $urandom;
            issue(encode_upper(rv_isa_pkg::op_lui, 5'(r), value[31:12] + 20'(value[11])), 1);
            issue(encode_imm_op(value[11:0], 5'(r), rv_isa_pkg::f3_add, 5'(r)), 1);
        end
        repeat (n_random) begin
            f3  = 3'($urandom);
            alt = (f3 == rv_isa_pkg::f3_add || f3 == rv_isa_pkg::f3_srl) ? 1'($urandom) : 1'b0;
            word = encode_reg_op(alt, 5'($urandom), f3, 5'($urandom), 5'($urandom));
            issue(word, 1 + $urandom_range(0, max_gap - 1));
        end
        finish_test("reg_ops");

        repeat (n_random) begin
            f3  = 3'($urandom);
            imm = 12'($urandom);
            if (f3 == rv_isa_pkg::f3_sll) begin
                imm[11:5] = 7'b0;
            end else if (f3 == rv_isa_pkg::f3_srl) begin
                imm[11:5] = {1'b0, 1'($urandom), 5'b0}; // SRAI or SRLI
            end
            word = encode_imm_op(imm, 5'($urandom), f3, 5'($urandom));
            issue(word, 1 + $urandom_range(0, max_gap - 1));
        end
        finish_test("imm_ops");

        repeat (20) begin
            rd   = 5'($urandom_range(1, 31));
            word = encode_upper(($urandom & 1) ? rv_isa_pkg::op_lui : rv_isa_pkg::op_auipc, rd,
                                20'($urandom));
            issue(word, 1);
        end
        finish_test("upper_imm");

        // Dependent chain on x0 to x3 with one strobe per cycle
        repeat (n_random) begin
            rd  = 5'($urandom_range(0, 3));
            rs1 = 5'($urandom_range(0, 3));
            rs2 = 5'($urandom_range(0, 3));
            if ($urandom & 1) begin
                word = encode_reg_op(1'b0, rd, rv_isa_pkg::f3_add, rs1, rs2);
            end else begin
                word = encode_imm_op(12'($urandom_range(1, 63)), rd, rv_isa_pkg::f3_add, rs1);
            end
            issue(word, 0);
        end
        finish_test("back_to_back");

        repeat (30) begin
            sel = $urandom_range(0, 2);
            case (sel)
                0:       word = encode_upper(rv_isa_pkg::op_auipc, 5'($urandom_range(1, 31)),
                                             20'($urandom));
                1:       word = {25'($urandom), 7'b0000011}; // Load
                default: word = {25'($urandom), 7'b1101111}; // JAL
            endcase
            issue(word, $urandom_range(0, 1));
        end
        finish_test("unsupported");

        $display("Summary: %0d tests, %0d failed, %0d write-backs checked, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/rv_core_properties.sv
// Timing assertions for the RV32I core, bound into the core top level
`default_nettype none

module rv_core_properties (
    input wire logic                  clk,
    input wire logic                  reset,
    input wire logic                  exec_valid,
    input wire logic                  wb_valid,
    input wire rv_isa_pkg::reg_addr_t wb_rd,
    input wire rv_isa_pkg::word_t     wb_data
);

    timeunit 1ns;
    timeprecision 1ps;

    // Quiet pipeline through reset and the first cycle after release
    reset_quiet: assert property (@(posedge clk) reset |=> !wb_valid)
        else $error("wb_valid high while in reset");
    release_quiet: assert property (@(posedge clk) $fell(reset) |-> !wb_valid ##1 !wb_valid)
        else $error("wb_valid high in the cycle after reset release");

    // Execute stage takes exactly one cycle
    exec_to_wb: assert property (@(posedge clk) disable iff (reset) exec_valid |=> wb_valid)
        else $error("no write-back one cycle after a decoded instruction");
    no_stray_wb: assert property (@(posedge clk) disable iff (reset) !exec_valid |=> !wb_valid)
        else $error("write-back without a decoded instruction");

    wb_known: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> !$isunknown({wb_rd, wb_data}))
        else $error("write-back with unknown destination or data");

endmodule

bind rv_core rv_core_properties props0 (
    .clk        (clk),
    .reset      (reset),
    .exec_valid (exec_bus.valid),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
);

`default_nettype wire

// File: verilog/rv_core.sv
// RV32I integer execution core: decode, register file and execute in three stages
`default_nettype none

module rv_core #(
    parameter rv_isa_pkg::word_t reset_pc = '0
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  instr_valid,
    input  wire rv_isa_pkg::word_t     instr,
    output logic                       wb_valid,
    output rv_isa_pkg::reg_addr_t      wb_rd,
    output rv_isa_pkg::word_t          wb_data
);

    rv_isa_pkg::reg_addr_t rs1_addr;
    rv_isa_pkg::reg_addr_t rs2_addr;
    rv_isa_pkg::word_t     rs1_data;
    rv_isa_pkg::word_t     rs2_data;

    rv_exec_if exec_bus ();

    rv_decode #(
        .reset_pc (reset_pc)
    ) decode0 (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .exec        (exec_bus.decode)
    );

    // Written back from the execute stage output
    rv_regfile regfile0 (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_valid),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data)
    );

    rv_execute execute0 (
        .clk      (clk),
        .reset    (reset),
        .exec     (exec_bus.execute),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

// File: verilog/rv_execute.sv
// Execute stage: operand selection, ALU and the EX/WB register
`default_nettype none

module rv_execute (
    input  wire logic               clk,
    input  wire logic               reset,
    rv_exec_if.execute              exec,
    output logic                    wb_valid,
    output rv_isa_pkg::reg_addr_t   wb_rd,
    output rv_isa_pkg::word_t       wb_data
);

    rv_isa_pkg::word_t op_a;
    rv_isa_pkg::word_t op_b;
    rv_isa_pkg::word_t alu_out;
    logic [4:0]        shamt;

    assign op_a  = exec.a_is_pc ? exec.pc : exec.rs1_data; // AUIPC uses pc
    assign shamt = op_b[4:0];

    // Second operand
    always_comb begin
        case (exec.b_sel)
            rv_ctrl_pkg::b_sel_imm_i: op_b = {{12{exec.imm[19]}}, exec.imm};
            rv_ctrl_pkg::b_sel_imm_u: op_b = {exec.imm, 12'b0};
            default:                  op_b = exec.rs2_data;
        endcase
    end

    always_comb begin
        case (exec.alu_op)
            rv_ctrl_pkg::alu_pass_b: alu_out = op_b;
            rv_ctrl_pkg::alu_add:    alu_out = op_a + op_b;
            rv_ctrl_pkg::alu_sub:    alu_out = op_a - op_b;
            rv_ctrl_pkg::alu_sll:    alu_out = op_a << shamt;
            rv_ctrl_pkg::alu_srl:    alu_out = op_a >> shamt;
            rv_ctrl_pkg::alu_sra:    alu_out = $signed(op_a) >>> shamt;
            rv_ctrl_pkg::alu_slt: begin
                alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            rv_ctrl_pkg::alu_sltu:   alu_out = {31'b0, op_a < op_b};
            rv_ctrl_pkg::alu_and:    alu_out = op_a & op_b;
            rv_ctrl_pkg::alu_or:     alu_out = op_a | op_b;
            rv_ctrl_pkg::alu_xor:    alu_out = op_a ^ op_b;
            default:                 alu_out = '0;
        endcase
    end

    // EX/WB register, also the register-file write port
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= exec.valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= exec.rd;
        wb_data <= alu_out;
    end

endmodule

`default_nettype wire

// File: verilog/rv_regfile.sv
// Register file: 31 writable registers, x0 tied to zero, write-to-read bypass
`default_nettype none

module rv_regfile (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire rv_isa_pkg::reg_addr_t  rs1_addr,
    input  wire rv_isa_pkg::reg_addr_t  rs2_addr,
    output rv_isa_pkg::word_t           rs1_data,
    output rv_isa_pkg::word_t           rs2_data,
    input  wire logic                   wr_en,
    input  wire rv_isa_pkg::reg_addr_t  wr_addr,
    input  wire rv_isa_pkg::word_t      wr_data
);

    rv_isa_pkg::word_t regs [1:31];
    logic              wr_live; // Write that actually lands

    assign wr_live = wr_en && (wr_addr != 5'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        if (rs1_addr == 5'd0) begin
            rs1_data = '0;
        end else if (wr_live && rs1_addr == wr_addr) begin
            rs1_data = wr_data; // Bypass
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    always_comb begin
        if (rs2_addr == 5'd0) begin
            rs2_data = '0;
        end else if (wr_live && rs2_addr == wr_addr) begin
            rs2_data = wr_data; // Bypass
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

`default_nettype wire

// File: verilog/rv_decode.sv
// Decode stage: instruction capture, program counter, control decode and ID/EX register
`default_nettype none

module rv_decode #(
    parameter rv_isa_pkg::word_t reset_pc = '0
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  instr_valid,
    input  wire rv_isa_pkg::word_t     instr,
    output rv_isa_pkg::reg_addr_t      rs1_addr,
    output rv_isa_pkg::reg_addr_t      rs2_addr,
    input  wire rv_isa_pkg::word_t     rs1_data,
    input  wire rv_isa_pkg::word_t     rs2_data,
    rv_exec_if.decode                  exec
);

    logic                  instr_valid_q;
    rv_isa_pkg::word_t     instr_q;
    rv_isa_pkg::word_t     instr_pc_q;  // pc of the captured instruction
    rv_isa_pkg::word_t     pc_next;     // pc for the next strobe
    rv_isa_pkg::opcode_t   opcode;
    rv_isa_pkg::funct3_t   funct3;
    logic                  alt;         // Bit 30 selects SUB or SRA
    rv_ctrl_pkg::alu_op_t  funct_op;
    rv_ctrl_pkg::alu_op_t  alu_op;
    rv_ctrl_pkg::b_sel_t   b_sel;
    logic                  a_is_pc;
    logic                  kept;
    logic [19:0]           imm;

    // Capture; every strobe advances pc, supported or not
    always_ff @(posedge clk) begin
        if (reset) begin
            instr_valid_q <= 1'b0;
            pc_next       <= reset_pc;
        end else begin
            instr_valid_q <= instr_valid;
            if (instr_valid) begin
                pc_next <= pc_next + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            instr_q    <= instr;
            instr_pc_q <= pc_next;
        end
    end

    assign opcode   = instr_q[6:0];
    assign funct3   = instr_q[14:12];
    assign alt      = instr_q[30];
    assign rs1_addr = instr_q[19:15];
    assign rs2_addr = instr_q[24:20];

    // funct3 to ALU operation, same table for register and immediate forms
    always_comb begin
        funct_op = rv_ctrl_pkg::alu_add;
        case (funct3)
            rv_isa_pkg::f3_add: begin
                // SUB exists only in the register form
                if (alt && opcode == rv_isa_pkg::op_reg) begin
                    funct_op = rv_ctrl_pkg::alu_sub;
                end else begin
                    funct_op = rv_ctrl_pkg::alu_add;
                end
            end
            rv_isa_pkg::f3_sll:  funct_op = rv_ctrl_pkg::alu_sll;
            rv_isa_pkg::f3_slt:  funct_op = rv_ctrl_pkg::alu_slt;
            rv_isa_pkg::f3_sltu: funct_op = rv_ctrl_pkg::alu_sltu;
            rv_isa_pkg::f3_xor:  funct_op = rv_ctrl_pkg::alu_xor;
            rv_isa_pkg::f3_srl:  funct_op = alt ? rv_ctrl_pkg::alu_sra : rv_ctrl_pkg::alu_srl;
            rv_isa_pkg::f3_or:   funct_op = rv_ctrl_pkg::alu_or;
            rv_isa_pkg::f3_and:  funct_op = rv_ctrl_pkg::alu_and;
            default:             funct_op = rv_ctrl_pkg::alu_add;
        endcase
    end

    always_comb begin
        alu_op  = funct_op;
        b_sel   = rv_ctrl_pkg::b_sel_reg;
        a_is_pc = 1'b0;
        kept    = 1'b1;
        imm     = {{8{instr_q[31]}}, instr_q[31:20]}; // I format by default
        case (opcode)
            rv_isa_pkg::op_reg: ;
            rv_isa_pkg::op_imm: b_sel = rv_ctrl_pkg::b_sel_imm_i;
            rv_isa_pkg::op_lui: begin
                alu_op = rv_ctrl_pkg::alu_pass_b;
                b_sel  = rv_ctrl_pkg::b_sel_imm_u;
                imm    = instr_q[31:12];
            end
            rv_isa_pkg::op_auipc: begin
                alu_op  = rv_ctrl_pkg::alu_add;
                b_sel   = rv_ctrl_pkg::b_sel_imm_u;
                a_is_pc = 1'b1;
                imm     = instr_q[31:12];
            end
            default: kept = 1'b0; // Dropped without write-back
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (reset) begin
            exec.valid <= 1'b0;
        end else begin
            exec.valid <= instr_valid_q && kept;
        end
    end

    always_ff @(posedge clk) begin
        exec.alu_op   <= alu_op;
        exec.a_is_pc  <= a_is_pc;
        exec.b_sel    <= b_sel;
        exec.rs1_data <= rs1_data;
        exec.rs2_data <= rs2_data;
        exec.imm      <= imm;
        exec.pc       <= instr_pc_q;
        exec.rd       <= instr_q[11:7];
    end

endmodule

`default_nettype wire

// File: verilog/rv_exec_if.sv
// Decoded instruction bundle passed from the decode stage to the execute stage
`default_nettype none

interface rv_exec_if;

    logic                   valid;    // One-cycle strobe
    rv_ctrl_pkg::alu_op_t   alu_op;
    logic                   a_is_pc;  // Operand A from pc instead of rs1
    rv_ctrl_pkg::b_sel_t    b_sel;
    rv_isa_pkg::word_t      rs1_data;
    rv_isa_pkg::word_t      rs2_data;
    logic [19:0]            imm;      // I field sign-extended to 20 bits, or U field
    rv_isa_pkg::word_t      pc;
    rv_isa_pkg::reg_addr_t  rd;

    modport decode (
        output valid, alu_op, a_is_pc, b_sel, rs1_data, rs2_data, imm, pc, rd
    );

    modport execute (
        input valid, alu_op, a_is_pc, b_sel, rs1_data, rs2_data, imm, pc, rd
    );

endinterface

`default_nettype wire

// File: verilog/rv_ctrl_pkg.sv
// Core control codes: ALU operations and second-operand selects
`default_nettype none

package rv_ctrl_pkg;

    typedef logic [3:0] alu_op_t;

    localparam alu_op_t alu_pass_b = 4'b0000; // LUI
    localparam alu_op_t alu_add    = 4'b0010;
    localparam alu_op_t alu_sub    = 4'b0011;
    localparam alu_op_t alu_sll    = 4'b0101;
    localparam alu_op_t alu_srl    = 4'b0110;
    localparam alu_op_t alu_sra    = 4'b0111;
    localparam alu_op_t alu_slt    = 4'b1000;
    localparam alu_op_t alu_sltu   = 4'b1001;
    localparam alu_op_t alu_and    = 4'b1010;
    localparam alu_op_t alu_or     = 4'b1011;
    localparam alu_op_t alu_xor    = 4'b1100;

    typedef logic [1:0] b_sel_t;

    localparam b_sel_t b_sel_reg   = 2'b00; // rs2 value
    localparam b_sel_t b_sel_imm_i = 2'b01; // Sign-extended 12-bit immediate
    localparam b_sel_t b_sel_imm_u = 2'b11; // Upper immediate, low 12 bits zero

endpackage

`default_nettype wire

// File: verilog/rv_isa_pkg.sv
// RV32I instruction-set definitions: word and field types, opcodes, funct3 codes
`default_nettype none

package rv_isa_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;     // Data or instruction word
    typedef logic [4:0]      reg_addr_t; // Register index
    typedef logic [6:0]      opcode_t;   // Major opcode
    typedef logic [2:0]      funct3_t;   // Minor function

    // Major opcodes of the supported integer subset
    localparam opcode_t op_reg   = 7'b0110011;
    localparam opcode_t op_imm   = 7'b0010011;
    localparam opcode_t op_lui   = 7'b0110111;
    localparam opcode_t op_auipc = 7'b0010111;

    // funct3 values, shared by the register and immediate forms
    localparam funct3_t f3_add  = 3'b000; // ADD and SUB
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_srl  = 3'b101; // SRL and SRA
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;

endpackage

`default_nettype wire
